//--- compile.f
merge_tree_pkg.sv
prog_fifo.sv
leaf_fetch.sv
merge_node.sv
merge_tree.sv
merge_tree_assertions.sv
tb_merge_tree.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_merge_tree
FILELIST   := compile.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_merge_tree.sv
module tb_merge_tree;
    timeunit 1ns;
    timeprecision 100ps;
    import merge_tree_pkg::*;

    localparam int NUM_LEAVES = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 300;                     // cycles per test before giving up

    logic                  i_clk;
    logic                  i_arst_n;
    rec_t [NUM_LEAVES-1:0] i_leaf_data;
    logic [NUM_LEAVES-1:0] i_leaf_vld;
    logic [NUM_LEAVES-1:0] o_leaf_read;
    logic                  i_root_read;
    rec_t                  o_root_data;
    logic                  o_root_vld;

    rec_t leaf_mem [NUM_LEAVES][64];                     // leaf buffer contents, no wrap
    int   leaf_head [NUM_LEAVES];
    int   leaf_tail [NUM_LEAVES];
    rec_t run_q [$];                                     // run being loaded, leaf order
    rec_t exp_q [$];
    rec_t got_q [$];
    logic read_en;                                       // root reader on or off
    int   quiet_cycles;                                  // cycles since the last leaf read
    int   seed = 32'h77c87de6;
    int   errors;
    int   tests_failed;

    merge_tree #(.NUM_LEAVES(NUM_LEAVES), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // leaf buffers and root reader
    //////////////////////////////////////////////////////////////////////

    initial begin : bus_model
        logic [NUM_LEAVES-1:0] rd_smp;
        logic                  root_smp;
        rec_t                  root_smp_data;
        i_leaf_data  = '0;
        i_leaf_vld   = '0;
        i_root_read  = 1'b0;
        quiet_cycles = 0;
        forever begin
            @(negedge i_clk);                            // strobes are settled mid-cycle
            rd_smp        = o_leaf_read;
            root_smp      = i_root_read;
            root_smp_data = o_root_data;
            @(posedge i_clk);
            #1;
            for (int i = 0; i < NUM_LEAVES; i++) begin
                if (rd_smp[i]) leaf_head[i]++;
                i_leaf_vld[i]  = (leaf_head[i] != leaf_tail[i]);
                i_leaf_data[i] = leaf_mem[i][leaf_head[i]];   // FWFT head
            end
            if (root_smp) got_q.push_back(root_smp_data);
            quiet_cycles = (rd_smp == '0) ? quiet_cycles + 1 : 0;
            i_root_read  = read_en && o_root_vld;
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * 400) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * 400);
        $display("Finished with errors");
        $finish;
    end

    function automatic int rand_below(input int span);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % span;
    endfunction

    // kind 0 distinct keys, 1 equal keys, 2 long runs, 3 random runs
    task automatic load_run(input int kind, input int run);
        rec_t r;
        int   len;
        int   key;
        int   j;
        for (int l = 0; l < NUM_LEAVES; l++) begin
            len = (kind == 3) ? 1 + rand_below(6) : ((kind == 2) ? 10 : 4);
            key = (kind == 3) ? rand_below(16) : ((kind == 1) ? 10 : l * 3 + 1);
            for (int k = 0; k < len; k++) begin
                r.last    = (k == len - 1);
                r.key     = key_t'(key);
                r.payload = payload_t'(run * 4096 + l * 256 + k);   // run, leaf, position
                leaf_mem[l][leaf_tail[l]] = r;
                leaf_tail[l]++;
                run_q.push_back(r);
                key += (kind == 3) ? rand_below(8) : ((kind == 1) ? 10 : 16);
            end
        end
        // stable insertion sort by key, equal keys keep leaf order
        for (int i = 1; i < run_q.size(); i++) begin
            r = run_q[i];
            j = i - 1;
            while (j >= 0 && run_q[j].key > r.key) begin
                run_q[j + 1] = run_q[j];
                j--;
            end
            run_q[j + 1] = r;
        end
        for (int i = 0; i < run_q.size(); i++) begin
            r      = run_q[i];
            r.last = (i == run_q.size() - 1);            // one end flag per merged run
            exp_q.push_back(r);
        end
        run_q.delete();
    endtask

    task automatic report_test(input string name, input int errs);
        errors += errs;
        if (errs != 0) tests_failed++;
        $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // short idle window after the last record catches duplicates
    task automatic collect_and_check(input string name, input int errs_in);
        int cycles;
        int errs;
        cycles = 0;
        errs   = errs_in;
        while (got_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        repeat (10) @(posedge i_clk);
        if (got_q.size() != exp_q.size()) begin
            $display("%s: root delivered %0d records, %0d expected", name, got_q.size(),
                     exp_q.size());
            errs++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i] !== exp_q[i]) begin
                $display("MISMATCH %s record %0d: o_root_data got %h expected %h", name, i,
                         got_q[i], exp_q[i]);
                errs++;
            end
        end
        got_q.delete();
        exp_q.delete();
        report_test(name, errs);
    endtask

    task automatic test_reset();
        int errs;
        errs = 0;
        for (int c = 0; c < 11; c++) begin
            @(posedge i_clk);
            #1;
            i_arst_n = (c >= 8);                         // released after 8 cycles
            @(negedge i_clk);
            if (o_root_vld !== 1'b0) begin
                $display("MISMATCH reset cycle %0d: o_root_vld got %h expected 0", c,
                         o_root_vld);
                errs++;
            end
            if (o_leaf_read !== '0) begin
                $display("MISMATCH reset cycle %0d: o_leaf_read got %h expected 0", c,
                         o_leaf_read);
                errs++;
            end
        end
        report_test("reset", errs);
    endtask

    task automatic test_simple();
        load_run(0, 0);
        collect_and_check("simple_merge", 0);
    endtask

    task automatic test_ties();
        load_run(1, 0);
        collect_and_check("equal_keys", 0);
    endtask

    task automatic test_backpressure();
        int   cycles;
        int   left;
        int   errs;
        logic started;
        cycles  = 0;
        left    = 0;
        errs    = 0;
        started = 1'b0;
        read_en = 1'b0;
        load_run(2, 0);
        // reads start, then stay off once the node FIFOs back up
        while (cycles < WAIT_LIMIT && !(started && quiet_cycles >= 20)) begin
            @(posedge i_clk);
            cycles++;
            if (quiet_cycles == 0) started = 1'b1;
        end
        @(negedge i_clk);
        for (int l = 0; l < NUM_LEAVES; l++) begin
            left += leaf_tail[l] - leaf_head[l];
        end
        if (!started || quiet_cycles < 20 || left == 0) begin
            $display("backpressure: leaf reads did not stall while the root was held off");
            errs++;
        end
        // the tree fills from the root down, so the root buffer holds data at the stall
        if (o_root_vld !== 1'b1) begin
            $display("backpressure: root buffer empty while leaf reads were stalled");
            errs++;
        end
        read_en = 1'b1;
        collect_and_check("backpressure", errs);
    endtask

    task automatic test_random();
        for (int r = 0; r < 3; r++) begin
            load_run(3, r);                              // three runs back to back
        end
        collect_and_check("random_runs", 0);
    endtask

    initial begin
        i_arst_n     = 1'b0;
        read_en      = 1'b0;
        errors       = 0;
        tests_failed = 0;
        test_reset();
        read_en = 1'b1;
        test_simple();
        test_ties();
        test_backpressure();
        test_random();
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", NUM_TESTS,
                 tests_failed, errors, dut0.u_chk.fail_count);
        if (errors == 0 && dut0.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- merge_tree_assertions.sv
module merge_tree_assertions #(
    parameter int NUM_LEAVES = 4
) (
    input logic                  i_clk,
    input logic                  i_arst_n,
    input logic [NUM_LEAVES-1:0] i_leaf_vld,
    input logic [NUM_LEAVES-1:0] o_leaf_read,
    input logic                  i_root_read,
    input logic                  o_root_vld
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // a leaf is popped only while it shows a record
    leaf_read_needs_vld: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_leaf_read & ~i_leaf_vld) == '0)
    else begin
        fail_count++;
        $error("o_leaf_read high without i_leaf_vld");
    end

    root_read_needs_vld: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_root_read |-> o_root_vld)
    else begin
        fail_count++;
        $error("i_root_read high without o_root_vld");
    end

    quiet_in_reset: assert property (@(posedge i_clk)
        !i_arst_n |-> (!o_root_vld && o_leaf_read == '0))
    else begin
        fail_count++;
        $error("o_root_vld or o_leaf_read high during reset");
    end

endmodule

bind merge_tree merge_tree_assertions #(.NUM_LEAVES(NUM_LEAVES)) u_chk (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_leaf_vld  (i_leaf_vld),
    .o_leaf_read (o_leaf_read),
    .i_root_read (i_root_read),
    .o_root_vld  (o_root_vld)
);

//--- merge_tree.sv
module merge_tree #(
    parameter int NUM_LEAVES = 4,   // power of two, at least 2
    parameter int FIFO_DEPTH = 8    // per node output FIFO
) (
    input  logic                                    i_clk,
    input  logic                                    i_arst_n,

    input  merge_tree_pkg::rec_t [NUM_LEAVES-1:0]   i_leaf_data,   // FWFT head of each leaf
    input  logic [NUM_LEAVES-1:0]                   i_leaf_vld,
    output logic [NUM_LEAVES-1:0]                   o_leaf_read,

    input  logic                                    i_root_read,   // only while o_root_vld
    output merge_tree_pkg::rec_t                    o_root_data,
    output logic                                    o_root_vld
);
    import merge_tree_pkg::*;

    localparam int NUM_NODES = NUM_LEAVES - 1;
    localparam int TREE_SIZE = 2 * NUM_LEAVES - 1;

    // heap order: entries 0..NUM_NODES-1 are node FIFO outputs,
    // the rest are the leaf prefetch registers, leaf 0 first
    rec_t [TREE_SIZE-1:0] tree_rec;
    logic [TREE_SIZE-1:0] tree_vld;
    logic [TREE_SIZE-1:0] tree_take;   // read strobe from the parent

    leaf_fetch #(
        .NUM_LEAVES (NUM_LEAVES)
    ) u_leaf_fetch (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_leaf_data (i_leaf_data),
        .i_leaf_vld  (i_leaf_vld),
        .o_leaf_read (o_leaf_read),
        .o_rec       (tree_rec[TREE_SIZE-1:NUM_NODES]),
        .o_rec_vld   (tree_vld[TREE_SIZE-1:NUM_NODES]),
        .i_take      (tree_take[TREE_SIZE-1:NUM_NODES])
    );

    //////////////////////////////////////////////////////////////////////
    // node n merges children 2n+1 and 2n+2
    //////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        merge_node #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_merge_node (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_rec_0  (tree_rec[2*n+1]),
            .i_vld_0  (tree_vld[2*n+1]),
            .i_rec_1  (tree_rec[2*n+2]),
            .i_vld_1  (tree_vld[2*n+2]),
            .o_take_0 (tree_take[2*n+1]),
            .o_take_1 (tree_take[2*n+2]),
            .i_pop    (tree_take[n]),
            .o_rec    (tree_rec[n]),
            .o_vld    (tree_vld[n])
        );
    end

    // the root node FIFO is the root buffer
    assign tree_take[0] = i_root_read;
    assign o_root_data  = tree_rec[0];
    assign o_root_vld   = tree_vld[0];

endmodule

//--- merge_node.sv
module merge_node #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 i_clk,
    input  logic                 i_arst_n,

    // two sorted input runs
    input  merge_tree_pkg::rec_t i_rec_0,
    input  logic                 i_vld_0,
    input  merge_tree_pkg::rec_t i_rec_1,
    input  logic                 i_vld_1,
    output logic                 o_take_0,   // consume i_rec_0 this cycle
    output logic                 o_take_1,   // consume i_rec_1 this cycle

    // merged run out of the node FIFO
    input  logic                 i_pop,
    output merge_tree_pkg::rec_t o_rec,
    output logic                 o_vld
);
    import merge_tree_pkg::*;

    merge_state_t state;
    merge_state_t state_nxt;
    logic         pick_1;        // input 1 holds the smaller key
    logic         take_0;
    logic         take_1;
    rec_t         sel_rec;       // taken record, last flag adjusted
    logic         wr_vld;        // write register toward the FIFO
    rec_t         wr_rec;
    logic         fifo_empty;
    logic         fifo_prog_full;

    //////////////////////////////////////////////////////////////////////
    // compare and select
    //////////////////////////////////////////////////////////////////////

    assign pick_1 = (i_rec_1.key < i_rec_0.key);   // tie goes to input 0

    always_comb begin
        take_0    = 1'b0;
        take_1    = 1'b0;
        sel_rec   = i_rec_0;
        state_nxt = state;
        case (state)
            ST_MERGE: begin
                if (i_vld_0 && i_vld_1 && !fifo_prog_full) begin
                    take_0 = !pick_1;
                    take_1 = pick_1;
                end
                sel_rec = pick_1 ? i_rec_1 : i_rec_0;
                // one run ended, the merged run goes on with the other
                if ((take_0 || take_1) && sel_rec.last) begin
                    state_nxt    = pick_1 ? ST_DRAIN_0 : ST_DRAIN_1;
                    sel_rec.last = 1'b0;
                end
            end
            ST_DRAIN_0: begin
                take_0  = i_vld_0 && !fifo_prog_full;
                sel_rec = i_rec_0;                       // forwarded as is
                if (take_0 && i_rec_0.last) state_nxt = ST_MERGE;
            end
            ST_DRAIN_1: begin
                take_1  = i_vld_1 && !fifo_prog_full;
                sel_rec = i_rec_1;
                if (take_1 && i_rec_1.last) state_nxt = ST_MERGE;
            end
            default: state_nxt = ST_MERGE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and write register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= ST_MERGE;
            wr_vld <= 1'b0;
        end else begin
            state  <= state_nxt;
            wr_vld <= take_0 || take_1;   // FIFO write one cycle after the take
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_0 || take_1) wr_rec <= sel_rec;
    end

    // threshold leaves room for the record still in the write register
    prog_fifo #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .PROG_FULL_THRESH (FIFO_DEPTH - 2)
    ) u_prog_fifo (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_wr_en     (wr_vld),
        .i_din       (wr_rec),
        .i_rd_en     (i_pop),
        .o_dout      (o_rec),
        .o_empty     (fifo_empty),
        .o_prog_full (fifo_prog_full)
    );

    assign o_take_0 = take_0;
    assign o_take_1 = take_1;
    assign o_vld    = !fifo_empty;

endmodule

//--- leaf_fetch.sv
module leaf_fetch #(
    parameter int NUM_LEAVES = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_arst_n,

    // external first-word-fall-through leaf buffers
    input  merge_tree_pkg::rec_t [NUM_LEAVES-1:0]   i_leaf_data,
    input  logic [NUM_LEAVES-1:0]                   i_leaf_vld,
    output logic [NUM_LEAVES-1:0]                   o_leaf_read,

    // toward the first tree level
    output merge_tree_pkg::rec_t [NUM_LEAVES-1:0]   o_rec,
    output logic [NUM_LEAVES-1:0]                   o_rec_vld,
    input  logic [NUM_LEAVES-1:0]                   i_take
);
    import merge_tree_pkg::*;

    rec_t [NUM_LEAVES-1:0] hold_rec;    // one-entry prefetch per leaf
    logic [NUM_LEAVES-1:0] hold_full;

    //////////////////////////////////////////////////////////////////////
    // refill control
    //////////////////////////////////////////////////////////////////////

    // read when the slot is free now or frees up at this edge
    assign o_leaf_read = i_leaf_vld & (~hold_full | i_take);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hold_full <= '0;
        end else begin
            hold_full <= o_leaf_read | (hold_full & ~i_take);   // refill wins over take
        end
    end

    //////////////////////////////////////////////////////////////////////
    // holding registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < NUM_LEAVES; i++) begin
            if (o_leaf_read[i]) begin
                hold_rec[i] <= i_leaf_data[i];   // shown one cycle after the read
            end
        end
    end

    assign o_rec     = hold_rec;
    assign o_rec_vld = hold_full;

endmodule

//--- prog_fifo.sv
module prog_fifo #(
    parameter int FIFO_DEPTH       = 8,
    parameter int PROG_FULL_THRESH = FIFO_DEPTH - 2
) (
    input  logic                 i_clk,
    input  logic                 i_arst_n,

    input  logic                 i_wr_en,       // push i_din at the edge
    input  merge_tree_pkg::rec_t i_din,

    input  logic                 i_rd_en,       // pop head at the edge
    output merge_tree_pkg::rec_t o_dout,        // head, first-word fall-through

    output logic                 o_empty,
    output logic                 o_prog_full    // count at or above threshold
);
    import merge_tree_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    rec_t mem [FIFO_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic do_wr;
    logic do_rd;

    // pointer advance with wrap, depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign do_wr = i_wr_en && (count != cnt_t'(FIFO_DEPTH));   // never overwrite the head
    assign do_rd = i_rd_en && !o_empty;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;             // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) mem[wr_ptr] <= i_din;
    end

    assign o_dout      = mem[rd_ptr];
    assign o_empty     = (count == '0);
    assign o_prog_full = (count >= cnt_t'(PROG_FULL_THRESH));

endmodule

//--- merge_tree_pkg.sv
package merge_tree_pkg;

    //////////////////////////////////////////////////////////////////////
    // record layout
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH    = 64;                       // key plus payload
    localparam int KEY_WIDTH     = 32;                       // upper bits, compared
    localparam int PAYLOAD_WIDTH = DATA_WIDTH - KEY_WIDTH;   // lower bits, carried along

    typedef logic [KEY_WIDTH-1:0]     key_t;       // ascending sort order
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;   // never compared

    // one record as it moves through the tree, 65 bits
    typedef struct packed {
        logic     last;      // end of run
        key_t     key;
        payload_t payload;
    } rec_t;

    //////////////////////////////////////////////////////////////////////
    // merge node FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_MERGE   = 2'd0,   // both runs open, compare keys
        ST_DRAIN_0 = 2'd1,   // run 1 done, forward input 0
        ST_DRAIN_1 = 2'd2    // run 0 done, forward input 1
    } merge_state_t;

endpackage
